/* verilog/cpu_pkg.sv */
// Shared ISA definitions for the pipelined core.
// Field positions, opcode and funct codes, ALU operations and widths.
// Files refer to these by scoped name.
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 16;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // instruction fields
    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 26;
    localparam int rs_msb     = 25;
    localparam int rs_lsb     = 21;
    localparam int rt_msb     = 20;
    localparam int rt_lsb     = 16;
    localparam int rd_msb     = 15;
    localparam int rd_lsb     = 11;
    localparam int funct_msb  = 5;
    localparam int funct_lsb  = 0;
    localparam int imm_msb    = 15;
    localparam int imm_lsb    = 0;

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;

    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_op_t;

    localparam word_t default_reset_pc = 32'h0040_0000;

endpackage

/* verilog/register_file.sv */
// General register file, 32 words, two read ports and one write port.
// A read of the register being written returns the new value.
`timescale 1ns/1ps

module register_file (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  cpu_pkg::reg_addr_t rd_addr_a,
    input  cpu_pkg::reg_addr_t rd_addr_b,
    output cpu_pkg::word_t     rd_data_a,
    output cpu_pkg::word_t     rd_data_b,
    input  logic               we,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data
);
    cpu_pkg::word_t regs [32];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && wr_addr != '0)        // r0 stays zero
            regs[wr_addr] <= wr_data;
    end

    assign rd_data_a = (rd_addr_a == '0) ? '0 :
                       (we && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 :
                       (we && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

/* verilog/fetch_stage.sv */
// Program counter of the fetch stage.
// The PC drives the instruction ROM address directly.
`timescale 1ns/1ps

module fetch_stage #(
    parameter cpu_pkg::word_t reset_pc = cpu_pkg::default_reset_pc
) (
    input  logic           SYS_clk,
    input  logic           SYS_reset,
    input  logic           stall,
    input  logic           freeze,
    input  logic           branch_taken,
    input  cpu_pkg::word_t branch_target,
    output cpu_pkg::word_t pc
);

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            pc <= reset_pc;
        else if (freeze || stall)
            pc <= pc;                        // hold on bus wait or hazard
        else if (branch_taken)
            pc <= branch_target;             // resolved in decode
        else
            pc <= pc + 32'd4;
    end

endmodule

/* verilog/decode_stage.sv */
// Decode stage: instruction register, control decode, register read
// with forwarding from the memory stage, and branch resolution.
// A taken branch squashes the instruction fetched behind it.
`timescale 1ns/1ps

module decode_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               stall,
    input  logic               freeze,
    input  cpu_pkg::word_t     imem_rdata,
    input  cpu_pkg::word_t     pc,
    input  logic               fwd_a,
    input  logic               fwd_b,
    input  cpu_pkg::word_t     mem_alu_result,
    input  logic               wb_we,
    input  cpu_pkg::reg_addr_t wb_addr,
    input  cpu_pkg::word_t     wb_data,
    output cpu_pkg::reg_addr_t src_rs,
    output cpu_pkg::reg_addr_t src_rt,
    output logic               uses_rs,
    output logic               uses_rt,
    output cpu_pkg::word_t     op_a,
    output cpu_pkg::word_t     op_b,
    output cpu_pkg::word_t     imm,
    output cpu_pkg::reg_addr_t dest,
    output logic               reg_write,
    output logic               mem_read,
    output logic               mem_write,
    output logic               alu_src_imm,
    output cpu_pkg::alu_op_t   alu_op,
    output logic               branch_taken,
    output cpu_pkg::word_t     branch_target
);
    cpu_pkg::word_t instr;
    cpu_pkg::word_t pc_d;
    cpu_pkg::word_t rf_a;
    cpu_pkg::word_t rf_b;
    logic [5:0]     opcode;
    logic [5:0]     funct;
    logic           dest_is_rt;
    logic           is_beq;
    logic           is_bne;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            instr <= '0;
            pc_d  <= '0;
        end
        else if (!freeze && !stall)
        begin
            instr <= branch_taken ? '0 : imem_rdata;   // squash slot as nop
            pc_d  <= pc;
        end
    end

    assign opcode = instr[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb];
    assign funct  = instr[cpu_pkg::funct_msb:cpu_pkg::funct_lsb];
    assign src_rs = instr[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
    assign src_rt = instr[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
    assign imm    = {{(cpu_pkg::xlen - cpu_pkg::imm_w){instr[cpu_pkg::imm_msb]}},
                     instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb]};
    assign dest   = dest_is_rt ? src_rt : instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];

    always_comb
    begin
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        alu_op      = cpu_pkg::alu_add;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        dest_is_rt  = 1'b0;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        case (opcode)
            cpu_pkg::op_rtype:
            begin
                reg_write = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                case (funct)
                    cpu_pkg::fn_add: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_sub: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and: alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:  alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_slt: alu_op = cpu_pkg::alu_slt;
                    default:
                    begin
                        reg_write = 1'b0;        // unknown funct runs as nop
                        uses_rs   = 1'b0;
                        uses_rt   = 1'b0;
                    end
                endcase
            end
            cpu_pkg::op_addi, cpu_pkg::op_lw:
            begin
                reg_write   = 1'b1;
                mem_read    = (opcode == cpu_pkg::op_lw);
                alu_src_imm = 1'b1;
                uses_rs     = 1'b1;
                dest_is_rt  = 1'b1;
            end
            cpu_pkg::op_sw:
            begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;              // store data
            end
            cpu_pkg::op_beq, cpu_pkg::op_bne:
            begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                is_beq  = (opcode == cpu_pkg::op_beq);
                is_bne  = (opcode == cpu_pkg::op_bne);
            end
            default: ;
        endcase
    end

    register_file regs (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .rd_addr_a(src_rs), .rd_addr_b(src_rt),
        .rd_data_a(rf_a), .rd_data_b(rf_b),
        .we(wb_we), .wr_addr(wb_addr), .wr_data(wb_data)
    );

    assign op_a = fwd_a ? mem_alu_result : rf_a;
    assign op_b = fwd_b ? mem_alu_result : rf_b;

    // compare on forwarded operands, decided in this cycle
    assign branch_taken  = (is_beq && (op_a == op_b)) || (is_bne && (op_a != op_b));
    assign branch_target = pc_d + 32'd4 + {imm[cpu_pkg::xlen-3:0], 2'b00};

endmodule

/* verilog/execute_stage.sv */
// Execute stage: decode/execute register and the ALU.
// A hazard stall loads a bubble with all controls cleared.
`timescale 1ns/1ps

module execute_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               freeze,
    input  logic               bubble,
    input  cpu_pkg::word_t     op_a,
    input  cpu_pkg::word_t     op_b,
    input  cpu_pkg::word_t     imm,
    input  cpu_pkg::reg_addr_t dest,
    input  logic               reg_write,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               alu_src_imm,
    input  cpu_pkg::alu_op_t   alu_op,
    output cpu_pkg::word_t     alu_result,
    output cpu_pkg::word_t     store_data,
    output cpu_pkg::reg_addr_t ex_dest,
    output logic               ex_reg_write,
    output logic               ex_mem_read,
    output logic               ex_mem_write
);
    cpu_pkg::word_t   a_r;
    cpu_pkg::word_t   imm_r;
    cpu_pkg::word_t   alu_b;
    logic             src_imm_r;
    cpu_pkg::alu_op_t alu_op_r;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            src_imm_r    <= 1'b0;
            alu_op_r     <= cpu_pkg::alu_add;
        end
        else if (!freeze)
        begin
            ex_reg_write <= reg_write && !bubble;        // bubble clears all controls
            ex_mem_read  <= mem_read && !bubble;
            ex_mem_write <= mem_write && !bubble;
            src_imm_r    <= alu_src_imm && !bubble;
            alu_op_r     <= bubble ? cpu_pkg::alu_add : alu_op;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!freeze)
        begin
            a_r        <= op_a;
            store_data <= op_b;              // rt value, also sw data
            imm_r      <= imm;
            ex_dest    <= dest;
        end
    end

    assign alu_b = src_imm_r ? imm_r : store_data;

    always_comb
    begin
        case (alu_op_r)
            cpu_pkg::alu_sub: alu_result = a_r - alu_b;
            cpu_pkg::alu_and: alu_result = a_r & alu_b;
            cpu_pkg::alu_or:  alu_result = a_r | alu_b;
            cpu_pkg::alu_slt: alu_result = {31'b0, $signed(a_r) < $signed(alu_b)};
            default:          alu_result = a_r + alu_b;    // wraps
        endcase
    end

endmodule

/* verilog/memory_stage.sv */
// Memory stage: execute/memory register acting as Wishbone classic master,
// then the memory/writeback register feeding the register file.
// The request holds until ack, and mem_busy freezes the pipeline meanwhile.
`timescale 1ns/1ps

module memory_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  cpu_pkg::word_t     alu_result,
    input  cpu_pkg::word_t     store_data,
    input  cpu_pkg::reg_addr_t ex_dest,
    input  logic               ex_reg_write,
    input  logic               ex_mem_read,
    input  logic               ex_mem_write,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output cpu_pkg::word_t     wb_adr,
    output cpu_pkg::word_t     wb_dat_o,
    output logic [3:0]         wb_sel,
    input  cpu_pkg::word_t     wb_dat_i,
    input  logic               wb_ack,
    output cpu_pkg::word_t     mem_alu_result,
    output cpu_pkg::reg_addr_t mem_dest,
    output logic               mem_reg_write,
    output logic               mem_is_load,
    output logic               mem_busy,
    output logic               wb_we_rf,
    output cpu_pkg::reg_addr_t wb_addr_rf,
    output cpu_pkg::word_t     wb_data_rf
);
    cpu_pkg::word_t m_store_data;
    logic           m_mem_write;
    logic           request;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            mem_reg_write <= 1'b0;
            mem_is_load   <= 1'b0;
            m_mem_write   <= 1'b0;
            wb_we_rf      <= 1'b0;
        end
        else if (!mem_busy)
        begin
            mem_reg_write <= ex_reg_write;
            mem_is_load   <= ex_mem_read;
            m_mem_write   <= ex_mem_write;
            wb_we_rf      <= mem_reg_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!mem_busy)
        begin
            mem_alu_result <= alu_result;
            m_store_data   <= store_data;
            mem_dest       <= ex_dest;
            wb_addr_rf     <= mem_dest;
            wb_data_rf     <= mem_is_load ? wb_dat_i : mem_alu_result;   // load data on ack
        end
    end

    assign request  = mem_is_load || m_mem_write;
    assign mem_busy = request && !wb_ack;

    assign wb_cyc   = request;
    assign wb_stb   = request;
    assign wb_we    = m_mem_write;
    assign wb_adr   = mem_alu_result;
    assign wb_dat_o = m_store_data;
    assign wb_sel   = 4'hf;                  // word access only

endmodule

/* verilog/hazard_unit.sv */
// Hazard detection for the decode stage.
// Stalls on a producer in execute or a load in memory,
// and forwards a non-load result from the memory stage.
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::reg_addr_t src_rs,
    input  cpu_pkg::reg_addr_t src_rt,
    input  logic               uses_rs,
    input  logic               uses_rt,
    input  cpu_pkg::reg_addr_t ex_dest,
    input  logic               ex_reg_write,
    input  cpu_pkg::reg_addr_t mem_dest,
    input  logic               mem_reg_write,
    input  logic               mem_is_load,
    output logic               stall,
    output logic               fwd_a,
    output logic               fwd_b
);
    logic ex_hit_rs;
    logic ex_hit_rt;
    logic mem_hit_rs;
    logic mem_hit_rt;

    // r0 never counts as a dependency
    assign ex_hit_rs  = ex_reg_write && ex_dest == src_rs && src_rs != '0 && uses_rs;
    assign ex_hit_rt  = ex_reg_write && ex_dest == src_rt && src_rt != '0 && uses_rt;
    assign mem_hit_rs = mem_reg_write && mem_dest == src_rs && src_rs != '0 && uses_rs;
    assign mem_hit_rt = mem_reg_write && mem_dest == src_rt && src_rt != '0 && uses_rt;

    assign stall = ex_hit_rs || ex_hit_rt || (mem_is_load && (mem_hit_rs || mem_hit_rt));
    assign fwd_a = mem_hit_rs && !mem_is_load;
    assign fwd_b = mem_hit_rt && !mem_is_load;

endmodule

/* verilog/cpu_core.sv */
// Top level of the five-stage pipelined core.
// Instruction fetch goes through a combinational ROM port,
// data accesses through a Wishbone classic master.
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::word_t reset_pc = cpu_pkg::default_reset_pc
) (
    input  logic           SYS_clk,
    input  logic           SYS_reset,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_rdata,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::word_t wb_dat_o,
    output logic [3:0]     wb_sel,
    input  cpu_pkg::word_t wb_dat_i,
    input  logic           wb_ack
);
    logic               stall;
    logic               mem_busy;            // freezes every stage
    logic               branch_taken;
    cpu_pkg::word_t     branch_target;
    logic               fwd_a;
    logic               fwd_b;
    cpu_pkg::reg_addr_t src_rs;
    cpu_pkg::reg_addr_t src_rt;
    logic               uses_rs;
    logic               uses_rt;
    cpu_pkg::word_t     op_a;
    cpu_pkg::word_t     op_b;
    cpu_pkg::word_t     imm;
    cpu_pkg::reg_addr_t dest;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               alu_src_imm;
    cpu_pkg::alu_op_t   alu_op;
    cpu_pkg::word_t     alu_result;
    cpu_pkg::word_t     store_data;
    cpu_pkg::reg_addr_t ex_dest;
    logic               ex_reg_write;
    logic               ex_mem_read;
    logic               ex_mem_write;
    cpu_pkg::word_t     mem_alu_result;
    cpu_pkg::reg_addr_t mem_dest;
    logic               mem_reg_write;
    logic               mem_is_load;
    logic               rf_we;               // writeback triple
    cpu_pkg::reg_addr_t rf_addr;
    cpu_pkg::word_t     rf_data;

    fetch_stage #(.reset_pc(reset_pc)) fetch (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .stall(stall), .freeze(mem_busy),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .pc(imem_addr)
    );

    decode_stage decode (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .stall(stall), .freeze(mem_busy),
        .imem_rdata(imem_rdata), .pc(imem_addr),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_alu_result(mem_alu_result),
        .wb_we(rf_we), .wb_addr(rf_addr), .wb_data(rf_data),
        .src_rs(src_rs), .src_rt(src_rt), .uses_rs(uses_rs), .uses_rt(uses_rt),
        .op_a(op_a), .op_b(op_b), .imm(imm), .dest(dest),
        .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
        .alu_src_imm(alu_src_imm), .alu_op(alu_op),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    execute_stage execute (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .freeze(mem_busy), .bubble(stall),
        .op_a(op_a), .op_b(op_b), .imm(imm), .dest(dest),
        .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
        .alu_src_imm(alu_src_imm), .alu_op(alu_op),
        .alu_result(alu_result), .store_data(store_data), .ex_dest(ex_dest),
        .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write)
    );

    memory_stage memory (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .alu_result(alu_result), .store_data(store_data), .ex_dest(ex_dest),
        .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .mem_alu_result(mem_alu_result), .mem_dest(mem_dest),
        .mem_reg_write(mem_reg_write), .mem_is_load(mem_is_load), .mem_busy(mem_busy),
        .wb_we_rf(rf_we), .wb_addr_rf(rf_addr), .wb_data_rf(rf_data)
    );

    hazard_unit hazard (
        .src_rs(src_rs), .src_rt(src_rt), .uses_rs(uses_rs), .uses_rt(uses_rt),
        .ex_dest(ex_dest), .ex_reg_write(ex_reg_write),
        .mem_dest(mem_dest), .mem_reg_write(mem_reg_write), .mem_is_load(mem_is_load),
        .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

endmodule

/* testbench/cpu_core_tb.sv */
// Testbench for the pipelined core.
// Builds a random program from a fixed LFSR seed and serves it from a ROM model.
// A Wishbone memory model with random wait states answers data accesses.
// Each completed access is compared with the access list of a sequential ISA model.
`timescale 1ns/1ps

module cpu_core_tb;
    localparam int prog_len       = 40;
    localparam int rand_count     = 33;                  // the last 7 are the result stores
    localparam int timeout_cycles = prog_len * 8 + 100;

    logic           SYS_clk;
    logic           SYS_reset;
    cpu_pkg::word_t imem_addr;
    cpu_pkg::word_t imem_rdata;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    cpu_pkg::word_t wb_adr;
    cpu_pkg::word_t wb_dat_o;
    logic [3:0]     wb_sel;
    cpu_pkg::word_t wb_dat_i;
    logic           wb_ack;

    cpu_pkg::word_t prog [prog_len];
    cpu_pkg::word_t dmem [16];
    cpu_pkg::word_t model_mem [16];
    cpu_pkg::word_t model_regs [32];
    logic           exp_we [$];
    cpu_pkg::word_t exp_adr [$];
    cpu_pkg::word_t exp_dat [$];
    cpu_pkg::word_t rom_idx;
    logic [31:0]    lfsr_state;
    int             errors;
    int             checks;
    int             done_count;
    int             cycles;
    int             taken;
    int             not_taken;
    int             wait_left;
    logic           req_seen;
    logic           ack_next;
    cpu_pkg::word_t dat_next;
    logic           prev_wait;
    logic           prev_we;
    cpu_pkg::word_t prev_adr;
    cpu_pkg::word_t prev_dat;

    cpu_core #(.reset_pc(cpu_pkg::default_reset_pc)) DUT (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    always #10 SYS_clk = ~SYS_clk;

    // instruction ROM, zero past the end of the program
    assign rom_idx    = (imem_addr - cpu_pkg::default_reset_pc) >> 2;
    assign imem_rdata = (rom_idx < prog_len) ? prog[rom_idx] : '0;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [5:0] funct_pick(input logic [2:0] sel);
        case (sel)
            3'd0:    return cpu_pkg::fn_add;
            3'd1:    return cpu_pkg::fn_sub;
            3'd2:    return cpu_pkg::fn_and;
            3'd3:    return cpu_pkg::fn_or;
            3'd4:    return cpu_pkg::fn_slt;
            3'd5:    return cpu_pkg::fn_add;
            3'd6:    return cpu_pkg::fn_slt;
            default: return 6'h3f;                            // undefined, runs as nop
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] bits;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        for (int i = 0; i < rand_count; i++)
        begin
            bits = take_bits(12);
            rs   = {2'b00, bits[8:6]};                        // registers 0 to 7
            rt   = {2'b00, bits[5:3]};
            rd   = {2'b00, bits[2:0]};
            case (bits[11:9])
                3'd0, 3'd1:
                    prog[i] = {cpu_pkg::op_rtype, rs, rt, rd, 5'b0, funct_pick(3'(take_bits(3)))};
                3'd3:
                    prog[i] = {cpu_pkg::op_lw, 5'd0, rt, 10'b0, 4'(take_bits(4)), 2'b00};
                3'd4:
                    prog[i] = {cpu_pkg::op_sw, 5'd0, rt, 10'b0, 4'(take_bits(4)), 2'b00};
                3'd5:
                    prog[i] = {cpu_pkg::op_beq, rs, rt, 16'(take_bits(2) % 3 + 1)};
                3'd6:
                    prog[i] = {cpu_pkg::op_bne, rs, rt, 16'(take_bits(2) % 3 + 1)};
                default:
                    prog[i] = {cpu_pkg::op_addi, rs, rt, 16'(take_bits(16))};
            endcase
        end
        for (int r = 1; r < 8; r++)                           // dump r1..r7 to words 8..14
            prog[rand_count + r - 1] = {cpu_pkg::op_sw, 5'd0, 5'(r), 16'((r + 7) * 4)};
        for (int m = 0; m < 16; m++)
        begin
            dmem[m]      = take_bits(32);
            model_mem[m] = dmem[m];
        end
    endtask

    // sequential execution, one instruction at a time
    task automatic run_model();
        cpu_pkg::word_t w;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t simm;
        cpu_pkg::word_t res;
        cpu_pkg::word_t addr;
        logic           wr;
        logic [4:0]     target;
        int             idx;
        idx = 0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        while (idx < prog_len)
        begin
            w      = prog[idx];
            a      = model_regs[w[25:21]];
            b      = model_regs[w[20:16]];
            simm   = {{16{w[15]}}, w[15:0]};
            addr   = a + simm;
            res    = a + simm;
            target = w[20:16];
            wr     = 1'b0;
            idx    = idx + 1;
            case (w[31:26])
                cpu_pkg::op_rtype:
                begin
                    target = w[15:11];
                    wr     = 1'b1;
                    case (w[5:0])
                        cpu_pkg::fn_add: res = a + b;
                        cpu_pkg::fn_sub: res = a - b;
                        cpu_pkg::fn_and: res = a & b;
                        cpu_pkg::fn_or:  res = a | b;
                        cpu_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:         wr  = 1'b0;
                    endcase
                end
                cpu_pkg::op_addi:
                    wr = 1'b1;
                cpu_pkg::op_lw:
                begin
                    wr  = 1'b1;
                    res = model_mem[addr[5:2]];
                    exp_we.push_back(1'b0);
                    exp_adr.push_back(addr);
                    exp_dat.push_back('0);
                end
                cpu_pkg::op_sw:
                begin
                    model_mem[addr[5:2]] = b;
                    exp_we.push_back(1'b1);
                    exp_adr.push_back(addr);
                    exp_dat.push_back(b);
                end
                cpu_pkg::op_beq, cpu_pkg::op_bne:
                begin
                    if ((a == b) == (w[31:26] == cpu_pkg::op_beq))
                    begin
                        idx   = idx + int'($signed(simm));
                        taken = taken + 1;
                    end
                    else
                        not_taken = not_taken + 1;
                end
                default: ;
            endcase
            if (wr && target != 5'd0)                         // r0 stays zero
                model_regs[target] = res;
        end
    endtask

    task automatic check_idle(input int cycle);
        checks = checks + 1;
        if (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || wb_we !== 1'b0)
        begin
            $display("** Error cyc/stb/we in reset cycle %0d: got %h%h%h expected 000",
                     cycle, wb_cyc, wb_stb, wb_we);
            errors = errors + 1;
        end
        if (imem_addr !== cpu_pkg::default_reset_pc)
        begin
            $display("** Error imem_addr: got %h expected %h", imem_addr, cpu_pkg::default_reset_pc);
            errors = errors + 1;
        end
    endtask

    task automatic check_access();
        checks = checks + 1;
        if (done_count >= exp_we.size())
        begin
            $display("unexpected %s access to address %h after all %0d expected accesses",
                     wb_we ? "store" : "load", wb_adr, exp_we.size());
            errors = errors + 1;
        end
        else
        begin
            if (wb_we !== exp_we[done_count])
            begin
                $display("** Error wb_we: got %h expected %h", wb_we, exp_we[done_count]);
                errors = errors + 1;
            end
            if (wb_adr !== exp_adr[done_count])
            begin
                $display("** Error wb_adr: got %h expected %h", wb_adr, exp_adr[done_count]);
                errors = errors + 1;
            end
            if (exp_we[done_count] && wb_dat_o !== exp_dat[done_count])
            begin
                $display("** Error wb_dat_o: got %h expected %h", wb_dat_o, exp_dat[done_count]);
                errors = errors + 1;
            end
        end
        if (wb_sel !== 4'hf || wb_cyc !== 1'b1)
        begin
            $display("** Error wb_sel/wb_cyc: got %h/%h expected f/1", wb_sel, wb_cyc);
            errors = errors + 1;
        end
        if (wb_we)
            dmem[wb_adr[5:2]] = wb_dat_o;
        done_count = done_count + 1;
    endtask

    // memory model, ack after 0 to 3 wait cycles
    always @(posedge SYS_clk)
    begin
        #2;
        ack_next = 1'b0;
        dat_next = '0;
        if (!SYS_reset && wb_stb)
        begin
            if (!req_seen)
            begin
                wait_left = take_bits(2);
                req_seen  = 1'b1;
            end
            if (wait_left == 0)
            begin
                ack_next = 1'b1;
                dat_next = dmem[wb_adr[5:2]];
                req_seen = 1'b0;
            end
            else
                wait_left = wait_left - 1;
        end
        wb_ack   = ack_next;
        wb_dat_i = dat_next;
    end

    // bus monitor, mid-cycle where outputs are settled
    always @(negedge SYS_clk)
    begin
        if (!SYS_reset && wb_stb && wb_ack)
            check_access();
        if (prev_wait)
        begin
            checks = checks + 1;
            if (!wb_stb)
            begin
                $display("Wishbone request to %h dropped before acknowledge", prev_adr);
                errors = errors + 1;
            end
            else if (wb_adr !== prev_adr || wb_we !== prev_we || wb_dat_o !== prev_dat)
            begin
                $display("** Error held request adr/we/dat_o: got %h/%h/%h expected %h/%h/%h",
                         wb_adr, wb_we, wb_dat_o, prev_adr, prev_we, prev_dat);
                errors = errors + 1;
            end
        end
        prev_wait = !SYS_reset && wb_stb && !wb_ack;
        prev_we   = wb_we;
        prev_adr  = wb_adr;
        prev_dat  = wb_dat_o;
    end

    initial
    begin
        SYS_reset = 1'b1;
        repeat (3) @(posedge SYS_clk);
        #2;
        SYS_reset = 1'b0;
    end

    initial
    begin
        SYS_clk    = 1'b0;
        wb_ack     = 1'b0;
        wb_dat_i   = '0;
        lfsr_state = 32'd67;
        errors     = 0;
        checks     = 0;
        done_count = 0;
        cycles     = 0;
        taken      = 0;
        not_taken  = 0;
        wait_left  = 0;
        req_seen   = 1'b0;
        prev_wait  = 1'b0;
        for (int i = 0; i < prog_len; i++)
            prog[i] = '0;
        build_program();
        run_model();
        checks = checks + 1;
        if (taken == 0 || not_taken == 0)                     // both branch outcomes needed
        begin
            $display("program lacks a taken or a not-taken branch: %0d taken, %0d not taken",
                     taken, not_taken);
            errors = errors + 1;
        end
        for (int c = 0; c < 3; c++)                           // two reset cycles, one after
        begin
            @(negedge SYS_clk);
            check_idle(c);
        end
        while (done_count < exp_we.size() && cycles < timeout_cycles)
        begin
            @(posedge SYS_clk);
            cycles = cycles + 1;
        end
        if (done_count < exp_we.size())
        begin
            $display("run timed out after %0d cycles with %0d of %0d accesses done",
                     cycles, done_count, exp_we.size());
            errors = errors + 1;
        end
        else
            repeat (20) @(posedge SYS_clk);                   // catch stray trailing accesses
        if (done_count != exp_we.size())
        begin
            $display("completed %0d bus accesses but the model expects %0d",
                     done_count, exp_we.size());
            errors = errors + 1;
        end
        $display("checks %0d, errors %0d, accesses %0d of %0d, branches taken %0d not taken %0d",
                 checks, errors, done_count, exp_we.size(), taken, not_taken);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* cpu_core.f */
verilog/cpu_pkg.sv
verilog/register_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/hazard_unit.sv
verilog/cpu_core.sv
testbench/cpu_core_tb.sv
